//--- flist.f
+incdir+source
source/serial_pkg.sv
source/elevator_pkg.sv
source/report_ctrl_if.sv
source/report_control.sv
source/record_cursor.sv
source/serial_sender.sv
source/report_datapath.sv
source/elevator_reporter.sv
tb/tb_elevator_reporter.sv

//--- run.sh
#!/bin/sh
# Build and run the elevator reporter simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f \
    --top-module tb_elevator_reporter \
    --Mdir obj_dir -o sim_elevator_reporter &&
./obj_dir/sim_elevator_reporter || exit 1

//--- tb/report_input.txt
# Columns, all hex: content bytes c0 c1 c2 c3, queue entries q0 to q7,
# expected frame count, then the expected bytes in the order they go out
# Origin calls spread over the queue, last slot sent
03 01 00 5A 85 12 80 7F 00 C4 33 91 8 03 01 00 5A 85 80 C4 91
# Empty queue
00 00 00 00 00 00 00 00 00 00 00 00 4 00 00 00 00
# Last slot skipped
0A 02 01 FF 8A 8B 8C 8D 8E 8F 90 11 B 0A 02 01 FF 8A 8B 8C 8D 8E 8F 90
# Every slot is an origin call
7F 01 00 20 FF FF FF FF FF FF FF FF C 7F 01 00 20 FF FF FF FF FF FF FF FF
# No origin flags but nonzero floors
15 00 01 40 7F 7E 7D 7C 7B 7A 79 78 4 15 00 01 40
# Only the last slot
01 02 03 04 00 00 00 00 00 00 00 81 5 01 02 03 04 81
# Only the first slot
55 AA 55 AA 80 00 00 00 00 00 00 00 5 55 AA 55 AA 80
# Alternating slots, last skipped
64 01 01 0C 01 86 02 8F 03 A0 04 05 7 64 01 01 0C 86 8F A0
# Same floor with and without origin
2A 02 00 80 9C 1C 9C 1C 9C 1C 9C 1C 8 2A 02 00 80 9C 9C 9C 9C
# Two scattered calls
FE 81 7E 00 00 92 00 00 B7 00 00 00 6 FE 81 7E 00 92 B7

//--- tb/tb_elevator_reporter.sv
`timescale 1ns/1ps
`include "report_defs.svh"

module tb_elevator_reporter;

    localparam int frame_limit  = `CONTENT_DEPTH + `QUEUE_DEPTH;
    localparam int field_count  = `CONTENT_DEPTH + `QUEUE_DEPTH + 1;
    localparam int gap_limit    = 100;   // Longest quiet stretch inside a report
    localparam int report_limit = 2000;
    localparam int start_limit  = 8;

    logic                         clock;
    logic                         reset;
    logic                         floor_changed;
    elevator_pkg::content_table_t content_table;
    elevator_pkg::queue_table_t   queue_table;
    logic                         tx;
    logic                         reporting;

    int                tokens[$];
    serial_pkg::byte_t received[$];
    serial_pkg::byte_t expected_bytes[$];

    elevator_reporter i_elevator_reporter (
        .clock         (clock),
        .reset         (reset),
        .floor_changed (floor_changed),
        .content_table (content_table),
        .queue_table   (queue_table),
        .tx            (tx),
        .reporting     (reporting)
    );

    always #4 clock = ~clock;

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input serial_pkg::byte_t actual,
                              input serial_pkg::byte_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_entry(input string name, input elevator_pkg::queue_entry_t actual,
                               input elevator_pkg::queue_entry_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    // Whitespace separated hex fields into tokens
    task automatic split_tokens(input string line);
        int    pos;
        int    start;
        byte   ch;
        string token;
        tokens.delete();
        start = 0;
        for (pos = 0; pos < line.len(); pos++) begin
            ch = line.getc(pos);
            if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r") begin
                if (pos > start) begin
                    token = line.substr(start, pos - 1);
                    tokens.push_back(token.atohex());
                end
                start = pos + 1;
            end
        end
        if (start < line.len()) begin
            token = line.substr(start, line.len() - 1);
            tokens.push_back(token.atohex());
        end
    endtask

    // Entered half a clock into the start bit
    task automatic receive_frame(output serial_pkg::byte_t value);
        int bit_pos;
        value = '0;
        repeat (`CLOCKS_PER_BIT / 2) @(negedge clock);
        if (tx !== 1'b0) begin
            $display("Start bit on tx ended before the middle of its bit time");
            stop_run();
        end
        for (bit_pos = 0; bit_pos < 8; bit_pos++) begin
            repeat (`CLOCKS_PER_BIT) @(negedge clock);
            value[bit_pos] = tx;  // LSB first
        end
        repeat (`CLOCKS_PER_BIT) @(negedge clock);
        if (tx !== 1'b1) begin
            $display("Stop bit on tx was not high");
            stop_run();
        end
    endtask

    task automatic receive_report();
        serial_pkg::byte_t value;
        int                idle_cycles;
        logic              done;
        received.delete();
        idle_cycles = 0;
        done        = 1'b0;
        while (!done) begin
            @(negedge clock);
            if (tx === 1'b0) begin
                receive_frame(value);
                received.push_back(value);
                idle_cycles = 0;
                if (received.size() > frame_limit) begin
                    $display("More frames arrived than one report can hold");
                    stop_run();
                end
            end else if (reporting !== 1'b1) begin
                done = 1'b1;
            end else begin
                idle_cycles++;
                if (idle_cycles > gap_limit) begin
                    $display("Timed out waiting for the next frame while reporting was high");
                    stop_run();
                end
            end
        end
    endtask

    // Random tables and stray floor_changed pulses while the report runs
    task automatic scramble_inputs();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            content_table = $urandom;
            queue_table   = {$urandom, $urandom};
            floor_changed = ($urandom_range(0, 7) == 0);
            @(negedge clock);
            cycles++;
            if (reporting !== 1'b1) begin
                floor_changed = 1'b0;
                done          = 1'b1;
            end else if (cycles > report_limit) begin
                $display("Timed out waiting for reporting to fall");
                stop_run();
            end
        end
    endtask

    task automatic await_reporting();
        int cycles;
        cycles = 0;
        while (reporting !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > start_limit) begin
                $display("Timed out waiting for reporting to rise after floor_changed");
                stop_run();
            end
        end
    endtask

    // Line must stay quiet until the next pulse
    task automatic hold_idle(input int cycles);
        int count;
        for (count = 0; count < cycles; count++) begin
            @(negedge clock);
            check_level("tx", tx, 1'b1);
            check_level("reporting", reporting, 1'b0);
        end
    endtask

    task automatic run_case(input int case_index, input elevator_pkg::content_table_t content,
                            input elevator_pkg::queue_table_t queue);
        int frame;
        content_table = content;
        queue_table   = queue;
        floor_changed = 1'b1;
        @(negedge clock);
        floor_changed = 1'b0;
        await_reporting();
        fork
            receive_report();
            scramble_inputs();
        join
        check_count($sformatf("case %0d frame count", case_index), received.size(),
                    expected_bytes.size());
        for (frame = 0; frame < received.size(); frame++) begin
            if (frame < `CONTENT_DEPTH) begin
                check_byte($sformatf("case %0d tx content byte %0d", case_index, frame),
                           received[frame], expected_bytes[frame]);
            end else begin
                check_entry($sformatf("case %0d tx queue entry %0d", case_index,
                                      frame - `CONTENT_DEPTH),
                            elevator_pkg::queue_entry_t'(received[frame]),
                            elevator_pkg::queue_entry_t'(expected_bytes[frame]));
            end
        end
        hold_idle($urandom_range(4, 40));
    endtask

    initial begin
        int                           fd;
        string                        line;
        int                           case_count;
        int                           index;
        int                           expected_count;
        elevator_pkg::content_table_t content;
        elevator_pkg::queue_table_t   queue;

        void'($urandom(32'h29cb));
        clock         = 1'b0;
        reset         = 1'b1;
        floor_changed = 1'b0;
        content_table = '0;
        queue_table   = '0;
        case_count    = 0;

        repeat (2) @(negedge clock);
        reset = 1'b0;
        check_level("tx", tx, 1'b1);
        check_level("reporting", reporting, 1'b0);
        hold_idle(3);

        fd = $fopen("tb/report_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/report_input.txt");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            split_tokens(line);
            if (tokens.size() == 0) begin
                continue;
            end
            if (tokens.size() < field_count) begin
                $display("Stimulus line has too few fields");
                stop_run();
            end
            expected_count = tokens[field_count - 1];
            if (expected_count < `CONTENT_DEPTH || expected_count > frame_limit ||
                tokens.size() != field_count + expected_count) begin
                $display("Stimulus line has a bad expected byte count");
                stop_run();
            end
            for (index = 0; index < `CONTENT_DEPTH; index++) begin
                content[index] = serial_pkg::byte_t'(tokens[index]);
            end
            for (index = 0; index < `QUEUE_DEPTH; index++) begin
                queue[index] = elevator_pkg::queue_entry_t'(
                    serial_pkg::byte_t'(tokens[`CONTENT_DEPTH + index]));
            end
            expected_bytes.delete();
            for (index = 0; index < expected_count; index++) begin
                expected_bytes.push_back(serial_pkg::byte_t'(tokens[field_count + index]));
            end
            case_count++;
            run_case(case_count, content, queue);
        end
        $fclose(fd);

        if (case_count == 0) begin
            $display("No test cases were found in the stimulus file");
            stop_run();
        end
        hold_idle(10);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- source/elevator_reporter.sv
`timescale 1ns/1ps

module elevator_reporter (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         floor_changed,
    input  elevator_pkg::content_table_t content_table,
    input  elevator_pkg::queue_table_t   queue_table,
    output logic                         tx,
    output logic                         reporting
);

    report_ctrl_if ctrl ();

    // Sequencing
    report_control i_report_control (
        .clock         (clock),
        .reset         (reset),
        .floor_changed (floor_changed),
        .reporting     (reporting),
        .ctrl          (ctrl.control)
    );

    // Snapshots and UART
    report_datapath i_report_datapath (
        .clock         (clock),
        .reset         (reset),
        .content_table (content_table),
        .queue_table   (queue_table),
        .tx            (tx),
        .ctrl          (ctrl.datapath)
    );

endmodule

//--- source/report_datapath.sv
`timescale 1ns/1ps
`include "report_defs.svh"

module report_datapath (
    input  logic                        clock,
    input  logic                        reset,
    input  elevator_pkg::content_table_t content_table,
    input  elevator_pkg::queue_table_t   queue_table,
    output logic                        tx,
    report_ctrl_if.datapath             ctrl
);

    serial_pkg::byte_t          content_byte;
    elevator_pkg::queue_entry_t queue_entry;
    serial_pkg::byte_t          tx_byte;

    // Status bytes
    record_cursor #(
        .entry_t (serial_pkg::byte_t),
        .DEPTH   (`CONTENT_DEPTH)
    ) i_content_cursor (
        .clock    (clock),
        .reset    (reset),
        .clear    (ctrl.clear),
        .count    (ctrl.count_content),
        .table_in (content_table),
        .entry    (content_byte),
        .last     (ctrl.content_last)
    );

    // Call queue
    record_cursor #(
        .entry_t (elevator_pkg::queue_entry_t),
        .DEPTH   (`QUEUE_DEPTH)
    ) i_queue_cursor (
        .clock    (clock),
        .reset    (reset),
        .clear    (ctrl.clear),
        .count    (ctrl.count_queue),
        .table_in (queue_table),
        .entry    (queue_entry),
        .last     (ctrl.queue_last)
    );

    assign tx_byte           = ctrl.content_select ? content_byte
                                                   : serial_pkg::byte_t'(queue_entry);
    assign ctrl.queue_origin = queue_entry.origin;

    serial_sender i_serial_sender (
        .clock (clock),
        .reset (reset),
        .send  (ctrl.send),
        .data  (tx_byte),
        .tx    (tx),
        .sent  (ctrl.sent)
    );

endmodule

//--- source/serial_sender.sv
`timescale 1ns/1ps
`include "report_defs.svh"

module serial_sender (
    input  logic              clock,
    input  logic              reset,
    input  logic              send,
    input  serial_pkg::byte_t data,
    output logic              tx,
    output logic              sent
);

    localparam int tick_width = (`CLOCKS_PER_BIT > 1) ? $clog2(`CLOCKS_PER_BIT) : 1;
    localparam logic [tick_width-1:0] tick_last = tick_width'(`CLOCKS_PER_BIT - 1);

    serial_pkg::sender_state_t state;
    serial_pkg::byte_t         shift_reg;
    logic [tick_width-1:0]     tick_count;
    logic [2:0]                bit_index;
    logic                      frame_start;
    logic                      bit_done;

    // No restart in the cycle that reports the previous frame
    assign frame_start = (state == serial_pkg::sender_idle) && send && !sent;
    assign bit_done    = (tick_count == tick_last);

    always_ff @(posedge clock) begin
        if (frame_start) begin
            shift_reg <= data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= serial_pkg::sender_idle;
            tick_count <= '0;
            bit_index  <= '0;
            tx         <= 1'b1;
            sent       <= 1'b0;
        end else begin
            sent <= 1'b0;
            case (state)
                serial_pkg::sender_idle: begin
                    tick_count <= '0;
                    if (frame_start) begin
                        state <= serial_pkg::sender_start;
                        tx    <= 1'b0;  // Start bit
                    end
                end
                serial_pkg::sender_start: begin
                    tick_count <= tick_count + 1'b1;
                    if (bit_done) begin
                        tick_count <= '0;
                        bit_index  <= '0;
                        state      <= serial_pkg::sender_data;
                        tx         <= shift_reg[0];
                    end
                end
                serial_pkg::sender_data: begin
                    tick_count <= tick_count + 1'b1;
                    if (bit_done) begin
                        tick_count <= '0;
                        if (bit_index == 3'd7) begin
                            state <= serial_pkg::sender_stop;
                            tx    <= 1'b1;  // Stop bit
                        end else begin
                            bit_index <= bit_index + 3'd1;
                            tx        <= shift_reg[bit_index + 3'd1];
                        end
                    end
                end
                serial_pkg::sender_stop: begin
                    tick_count <= tick_count + 1'b1;
                    if (bit_done) begin
                        tick_count <= '0;
                        state      <= serial_pkg::sender_idle;
                        sent       <= 1'b1;
                    end
                end
                default: begin
                    state <= serial_pkg::sender_idle;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- source/record_cursor.sv
`timescale 1ns/1ps

module record_cursor #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               clear,
    input  logic               count,
    input  entry_t [DEPTH-1:0] table_in,
    output entry_t             entry,
    output logic               last
);

    localparam int addr_width = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [addr_width-1:0] addr_last = addr_width'(DEPTH - 1);

    entry_t [DEPTH-1:0]    snapshot;
    logic [addr_width-1:0] address;

    // Table copy frozen once clear drops
    always_ff @(posedge clock) begin
        if (clear) begin
            snapshot <= table_in;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            address <= '0;
        end else if (clear) begin
            address <= '0;
        end else if (count) begin
            address <= address + 1'b1;
        end
    end

    assign entry = snapshot[address];
    assign last  = (address == addr_last);

endmodule

//--- source/report_control.sv
`timescale 1ns/1ps

module report_control (
    input  logic   clock,
    input  logic   reset,
    input  logic   floor_changed,
    output logic   reporting,
    report_ctrl_if.control ctrl
);

    typedef enum logic [2:0] {
        state_idle,
        state_prepare,
        state_send_content,
        state_count_content,
        state_check_queue,
        state_send_queue,
        state_count_queue,
        state_final
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            state_idle: begin
                if (floor_changed) begin
                    state_next = state_prepare;
                end
            end
            state_prepare:       state_next = state_send_content;
            state_send_content: begin
                if (ctrl.sent) begin
                    state_next = ctrl.content_last ? state_check_queue : state_count_content;
                end
            end
            state_count_content: state_next = state_send_content;
            state_check_queue: begin
                // Skip entries that are not origin calls
                if (ctrl.queue_origin) begin
                    state_next = state_send_queue;
                end else begin
                    state_next = ctrl.queue_last ? state_final : state_count_queue;
                end
            end
            state_send_queue: begin
                if (ctrl.sent) begin
                    state_next = ctrl.queue_last ? state_final : state_count_queue;
                end
            end
            state_count_queue:   state_next = state_check_queue;
            state_final:         state_next = state_idle;
            default:             state_next = state_idle;
        endcase
    end

    // Moore outputs
    always_comb begin
        ctrl.clear          = (state == state_idle) || (state == state_prepare);
        ctrl.count_content  = (state == state_count_content);
        ctrl.count_queue    = (state == state_count_queue);
        ctrl.send           = (state == state_send_content) || (state == state_send_queue);
        ctrl.content_select = (state == state_send_content) || (state == state_count_content);
        // Snapshot is already loaded once this goes high
        reporting           = !ctrl.clear;
    end

endmodule

//--- source/report_ctrl_if.sv
`timescale 1ns/1ps

interface report_ctrl_if;

    logic clear;           // Rewind cursors and load snapshots
    logic count_content;
    logic count_queue;
    logic send;            // Held for a whole frame
    logic content_select;  // Status bytes on the sender
    logic sent;            // End of frame strobe
    logic content_last;
    logic queue_last;
    logic queue_origin;

    modport control (
        output clear,
        output count_content,
        output count_queue,
        output send,
        output content_select,
        input  sent,
        input  content_last,
        input  queue_last,
        input  queue_origin
    );

    modport datapath (
        input  clear,
        input  count_content,
        input  count_queue,
        input  send,
        input  content_select,
        output sent,
        output content_last,
        output queue_last,
        output queue_origin
    );

endinterface

//--- source/elevator_pkg.sv
`include "report_defs.svh"

package elevator_pkg;

    // One pending call with the origin flag on top
    typedef struct packed {
        logic                      origin;
        logic [`FLOOR_WIDTH-1:0]   floor;
    } queue_entry_t;

    // Floor, direction, door and load bytes
    typedef serial_pkg::byte_t [`CONTENT_DEPTH-1:0] content_table_t;

    // Whole call queue with slot 0 in the low bits
    typedef queue_entry_t [`QUEUE_DEPTH-1:0] queue_table_t;

endpackage

//--- source/serial_pkg.sv
package serial_pkg;

    // Payload of one UART frame
    typedef logic [7:0] byte_t;

    // Transmitter phases
    typedef enum logic [1:0] {
        sender_idle,
        sender_start,
        sender_data,
        sender_stop
    } sender_state_t;

endpackage

//--- source/report_defs.svh
`ifndef REPORT_DEFS_SVH
`define REPORT_DEFS_SVH

// Status bytes per report
`define CONTENT_DEPTH 4
// Queue slots in the call table
`define QUEUE_DEPTH 8
// Line rate as clock cycles per bit
`define CLOCKS_PER_BIT 4
`define FLOOR_WIDTH 7

`endif
